/* dcache.f */
+incdir+tb
source/dcache_pkg.sv
source/dcache_ways.sv
source/dcache_lookup.sv
source/dcache_ctrl.sv
source/dcache.sv
tb/tb_dcache.sv

/* source/dcache.sv */
`timescale 1ns/1ps

module dcache #(
    parameter int INDEX_BITS = 3
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              dmemren,
    input  logic              dmemwen,
    input  dcache_pkg::word_t dmemaddr,
    input  dcache_pkg::word_t dmemstore,
    input  logic              halt,
    output dcache_pkg::word_t dmemload,
    output logic              dhit,
    output logic              flushed,
    output logic              dren,
    output logic              dwen,
    output dcache_pkg::word_t daddr,
    output dcache_pkg::word_t dstore,
    input  dcache_pkg::word_t dload,
    input  logic              dwait
);
    import dcache_pkg::*;

    localparam int TAG_BITS = 32 - INDEX_BITS - WORD_BITS - BYTE_BITS;

    // controller to storage
    logic [INDEX_BITS-1:0] idx;
    logic [WORD_BITS-1:0]  word_sel;
    way_t                  wr_way;
    logic                  wr_word, set_dirty, fill;
    word_t                 wr_data;
    logic [TAG_BITS-1:0]   fill_tag;

    // storage read side
    logic [1:0]            valid, dirty;
    logic [TAG_BITS-1:0]   tag0, tag1;
    word_t                 word0, word1;

    // lookup and controller handshake
    logic                  access_en, hit, fill_done;
    way_t                  hit_way, victim_way, fill_way;

    dcache_ways   #(.INDEX_BITS(INDEX_BITS)) ways_inst   (.*);
    dcache_lookup #(.INDEX_BITS(INDEX_BITS)) lookup_inst (.*);
    dcache_ctrl   #(.INDEX_BITS(INDEX_BITS)) ctrl_inst   (.*);

endmodule

/* source/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int INDEX_BITS = 3,
    localparam int TAG_BITS = 32 - INDEX_BITS - dcache_pkg::WORD_BITS - dcache_pkg::BYTE_BITS
) (
    input  logic                             CLK,
    input  logic                             nRST,
    input  logic                             dmemren,
    input  logic                             dmemwen,
    input  dcache_pkg::word_t                dmemaddr,
    input  dcache_pkg::word_t                dmemstore,
    input  logic                             halt,
    input  logic                             hit,
    input  dcache_pkg::way_t                 hit_way,
    input  dcache_pkg::way_t                 victim_way,
    input  logic [1:0]                       valid,
    input  logic [1:0]                       dirty,
    input  logic [TAG_BITS-1:0]              tag0,
    input  logic [TAG_BITS-1:0]              tag1,
    input  dcache_pkg::word_t                word0,
    input  dcache_pkg::word_t                word1,
    input  dcache_pkg::word_t                dload,
    input  logic                             dwait,
    output logic                             access_en,
    output logic [INDEX_BITS-1:0]            idx,
    output logic [dcache_pkg::WORD_BITS-1:0] word_sel,
    output dcache_pkg::way_t                 wr_way,
    output logic                             wr_word,
    output dcache_pkg::word_t                wr_data,
    output logic                             set_dirty,
    output logic                             fill,
    output logic [TAG_BITS-1:0]              fill_tag,
    output logic                             fill_done,
    output dcache_pkg::way_t                 fill_way,
    output logic                             dren,
    output logic                             dwen,
    output dcache_pkg::word_t                daddr,
    output dcache_pkg::word_t                dstore,
    output logic                             flushed
);
    import dcache_pkg::*;

    localparam int IDX_LSB = BYTE_BITS + WORD_BITS;

    dcache_state_t         state;
    dcache_state_t         next_state;
    logic [INDEX_BITS:0]   scan_cnt;  // msb is the way, way 0 first
    logic [INDEX_BITS:0]   next_scan_cnt;
    logic [TAG_BITS-1:0]   req_tag;
    logic [TAG_BITS-1:0]   op_tag;
    logic [INDEX_BITS-1:0] req_idx;
    way_t                  op_way;
    logic                  req;
    logic                  flushing;

    assign req_tag  = dmemaddr[31 -: TAG_BITS];
    assign req_idx  = dmemaddr[IDX_LSB +: INDEX_BITS];
    assign req      = dmemren || dmemwen;
    assign flushing = state inside {FLUSH_SCAN, FLUSH0, FLUSH1};

    // which line the storage looks at
    assign idx    = flushing ? scan_cnt[INDEX_BITS-1:0] : req_idx;
    assign op_way = flushing ? way_t'(scan_cnt[INDEX_BITS]) :
                    (state == ACCESS) ? hit_way : victim_way;
    assign op_tag = op_way ? tag1 : tag0;

    always_comb begin
        case (state)
            WB0, MEM0, FLUSH0: word_sel = '0;
            WB1, MEM1, FLUSH1: word_sel = WORD_BITS'(1);
            default:           word_sel = dmemaddr[BYTE_BITS +: WORD_BITS];
        endcase
    end

    // storage strobes
    assign access_en = (state == ACCESS) && req;
    assign set_dirty = access_en && dmemwen && hit;
    assign fill      = (state == MEM1) && !dwait;
    assign fill_done = fill;
    assign wr_word   = set_dirty || ((state inside {MEM0, MEM1}) && !dwait);
    assign wr_data   = (state == ACCESS) ? dmemstore : dload;
    assign wr_way    = op_way;
    assign fill_tag  = req_tag;
    assign fill_way  = victim_way;

    // memory port, held as a level until dwait drops
    assign dren    = state inside {MEM0, MEM1};
    assign dwen    = state inside {WB0, WB1, FLUSH0, FLUSH1};
    assign daddr   = (dren || dwen) ?
                     {(dren ? req_tag : op_tag), idx, word_sel, {BYTE_BITS{1'b0}}} : '0;
    assign dstore  = dwen ? (op_way ? word1 : word0) : '0;
    assign flushed = (state == HALTED);

    always_comb begin
        next_state    = state;
        next_scan_cnt = scan_cnt;
        case (state)
            ACCESS: begin
                if (req && !hit) begin
                    next_state = (valid[victim_way] && dirty[victim_way]) ? WB0 : MEM0;
                end else if (!req && halt) begin
                    next_state    = FLUSH_SCAN;
                    next_scan_cnt = '0;
                end
            end
            WB0:    if (!dwait) next_state = WB1;
            WB1:    if (!dwait) next_state = MEM0;
            MEM0:   if (!dwait) next_state = MEM1;
            MEM1:   if (!dwait) next_state = ACCESS;  // retry now hits
            FLUSH_SCAN: begin
                if (valid[op_way] && dirty[op_way]) begin
                    next_state = FLUSH0;
                end else if (&scan_cnt) begin
                    next_state = HALTED;
                end else begin
                    next_scan_cnt = scan_cnt + 1'b1;
                end
            end
            FLUSH0: if (!dwait) next_state = FLUSH1;
            FLUSH1: begin
                if (!dwait) begin
                    next_state    = (&scan_cnt) ? HALTED : FLUSH_SCAN;
                    next_scan_cnt = scan_cnt + 1'b1;
                end
            end
            default: next_state = state;  // HALTED until reset
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= ACCESS;
            scan_cnt <= '0;
        end else begin
            state    <= next_state;
            scan_cnt <= next_scan_cnt;
        end
    end

    a_one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(dren && dwen))
        else $error("dren and dwen together");

    // stalled transfer keeps the whole request steady
    a_hold_on_wait: assert property (@(posedge CLK) disable iff (!nRST)
        (dren || dwen) && dwait |=>
            $stable(dren) && $stable(dwen) && $stable(daddr) && $stable(dstore))
        else $error("memory request changed under dwait");

endmodule

/* source/dcache_lookup.sv */
`timescale 1ns/1ps

module dcache_lookup #(
    parameter int INDEX_BITS = 3,
    localparam int TAG_BITS = 32 - INDEX_BITS - dcache_pkg::WORD_BITS - dcache_pkg::BYTE_BITS
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                access_en,
    input  dcache_pkg::word_t   dmemaddr,
    input  logic [1:0]          valid,
    input  logic [TAG_BITS-1:0] tag0,
    input  logic [TAG_BITS-1:0] tag1,
    input  dcache_pkg::word_t   word0,
    input  dcache_pkg::word_t   word1,
    input  logic                fill_done,
    input  dcache_pkg::way_t    fill_way,
    output logic                hit,
    output dcache_pkg::way_t    hit_way,
    output dcache_pkg::way_t    victim_way,
    output logic                dhit,
    output dcache_pkg::word_t   dmemload
);
    import dcache_pkg::*;

    localparam int SETS    = 1 << INDEX_BITS;
    localparam int IDX_LSB = BYTE_BITS + WORD_BITS;

    logic [TAG_BITS-1:0]   req_tag;
    logic [INDEX_BITS-1:0] req_idx;
    logic                  hit0;
    logic                  hit1;
    logic [SETS-1:0]       mru;  // most recently used way per set

    assign req_tag = dmemaddr[31 -: TAG_BITS];
    assign req_idx = dmemaddr[IDX_LSB +: INDEX_BITS];

    assign hit0    = valid[0] && (tag0 == req_tag);
    assign hit1    = valid[1] && (tag1 == req_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = way_t'(hit1);

    assign victim_way = way_t'(!mru[req_idx]);

    assign dhit     = access_en && hit;
    assign dmemload = dhit ? (hit1 ? word1 : word0) : '0;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mru <= '0;
        end else if (fill_done) begin
            mru[req_idx] <= fill_way;  // new block counts as used
        end else if (dhit) begin
            mru[req_idx] <= hit_way;
        end
    end

    // the controller only fills the victim after a miss, so a tag never sits in both ways
    a_one_way_hit: assert property (@(posedge CLK) disable iff (!nRST)
        access_en |-> !(hit0 && hit1))
        else $error("both ways hit");

endmodule

/* source/dcache_pkg.sv */
package dcache_pkg;

    // data word or byte address
    typedef logic [31:0] word_t;

    // 0 is the left way, 1 the right way
    typedef logic way_t;

    localparam int BYTE_BITS = 2;
    localparam int WORD_BITS = 1;  // two words per block

    typedef enum logic [3:0] {
        ACCESS,
        WB0,
        WB1,
        MEM0,
        MEM1,
        FLUSH_SCAN,
        FLUSH0,
        FLUSH1,
        HALTED
    } dcache_state_t;

endpackage

/* source/dcache_ways.sv */
`timescale 1ns/1ps

module dcache_ways #(
    parameter int INDEX_BITS = 3,
    localparam int TAG_BITS = 32 - INDEX_BITS - dcache_pkg::WORD_BITS - dcache_pkg::BYTE_BITS
) (
    input  logic                             CLK,
    input  logic                             nRST,
    input  logic [INDEX_BITS-1:0]            idx,
    input  logic [dcache_pkg::WORD_BITS-1:0] word_sel,
    input  dcache_pkg::way_t                 wr_way,
    input  logic                             wr_word,
    input  dcache_pkg::word_t                wr_data,
    input  logic                             set_dirty,
    input  logic                             fill,
    input  logic [TAG_BITS-1:0]              fill_tag,
    output logic [1:0]                       valid,
    output logic [1:0]                       dirty,
    output logic [TAG_BITS-1:0]              tag0,
    output logic [TAG_BITS-1:0]              tag1,
    output dcache_pkg::word_t                word0,
    output dcache_pkg::word_t                word1
);
    import dcache_pkg::*;

    localparam int SETS  = 1 << INDEX_BITS;
    localparam int WORDS = 1 << WORD_BITS;

    logic [1:0]          valid_q [SETS];  // one bit per way
    logic [1:0]          dirty_q [SETS];
    logic [TAG_BITS-1:0] tag_mem [2][SETS];
    word_t               data_mem [2][SETS][WORDS];

    // line state
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (fill) begin
            valid_q[idx][wr_way] <= 1'b1;  // freshly filled line is clean
            dirty_q[idx][wr_way] <= 1'b0;
        end else if (wr_word && set_dirty) begin
            dirty_q[idx][wr_way] <= 1'b1;
        end
    end

    // tags and block words
    always_ff @(posedge CLK) begin
        if (fill) begin
            tag_mem[wr_way][idx] <= fill_tag;
        end
        if (wr_word) begin
            data_mem[wr_way][idx][word_sel] <= wr_data;
        end
    end

    // combinational read of the addressed set
    assign valid = valid_q[idx];
    assign dirty = dirty_q[idx];
    assign tag0  = tag_mem[0][idx];
    assign tag1  = tag_mem[1][idx];
    assign word0 = data_mem[0][idx][word_sel];  // left
    assign word1 = data_mem[1][idx][word_sel];  // right

    // store hits only happen in ACCESS, fills only at the end of MEM1
    a_fill_not_store: assert property (@(posedge CLK) disable iff (!nRST)
        !(fill && set_dirty))
        else $error("fill and store hit in the same cycle");

endmodule

/* tb/tb_dcache_util.svh */
`ifndef TB_DCACHE_UTIL_SVH
`define TB_DCACHE_UTIL_SVH

// one xorshift step, caller keeps the state
function automatic word_t xorshift32(input word_t x);
    word_t r;
    r = x ^ (x << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
endfunction

task automatic stop_with_failure(input string why);
    dcache_state_t st;
    st = dcache_inst.ctrl_inst.state;
    $display("%s (controller in %s)", why, st.name());
    $display("TB FAILED");
    $fatal(1);
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        $display("MISMATCH at time %0t: %s is %h, expected %h", $time, name, got, exp);
        stop_with_failure({name, " differs from the model"});
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("MISMATCH at time %0t: %s is %b, expected %b", $time, name, got, exp);
        stop_with_failure({name, " differs from the model"});
    end
endtask

`endif

/* tb/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int    INDEX_BITS = 3;
    localparam int    SETS       = 1 << INDEX_BITS;
    localparam int    N_OPS      = 1500;
    localparam int    MAX_CYCLES = N_OPS * 40;
    localparam word_t SEED       = 32'heb3fe50d;

    logic  CLK = 1'b0;
    logic  nRST;
    logic  dmemren, dmemwen, halt, dwait, dhit, flushed, dren, dwen;
    word_t dmemaddr, dmemstore, dload, dmemload, daddr, dstore;

    word_t mem [64];      // memory behind the cache
    word_t ref_mem [64];  // last value stored per word
    logic  m_valid [SETS][2];
    logic  m_dirty [SETS][2];
    int    m_tag [SETS][2];
    logic  m_mru [SETS];
    logic  exp_wr [$];    // 1 for a write-back word
    int    exp_word [$];  // word address of each expected transfer
    word_t wait_rng;
    int    wait_left = 0;
    int    cycles = 0;

    `include "tb_dcache_util.svh"

    dcache #(.INDEX_BITS(INDEX_BITS)) dcache_inst (.*);

    always #10 CLK = ~CLK;

    assign dload = mem[daddr[7:2]];

    // memory side with 0 to 3 wait cycles per word
    always @(posedge CLK) begin
        if (dwen && !dwait) begin
            mem[daddr[7:2]] <= dstore;
        end
        if ((dren || dwen) && !dwait) begin
            wait_rng  = xorshift32(wait_rng);
            wait_left = wait_rng % 4;
        end else if ((dren || dwen) && wait_left > 0) begin
            wait_left = wait_left - 1;
        end
        dwait <= (wait_left != 0);
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_with_failure($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    task automatic queue_block(input logic wr, input int base);
        for (int k = 0; k < 2; k++) begin
            exp_wr.push_back(wr);
            exp_word.push_back(base + k);
        end
    endtask

    // one memory cycle against the head of the expected transfers
    task automatic check_transfer();
        check_bit("dren", dren, !exp_wr[0]);
        check_bit("dwen", dwen, exp_wr[0]);
        check_word("daddr", daddr, word_t'(exp_word[0]) << 2);
        if (exp_wr[0]) begin
            check_word("dstore", dstore, ref_mem[exp_word[0]]);
        end
        if (!dwait) begin
            void'(exp_wr.pop_front());
            void'(exp_word.pop_front());
        end
    endtask

    task automatic run_access(input logic is_store, input int w, input word_t data);
        int   set;
        int   tag;
        int   way;
        logic found;
        set   = (w / 2) % SETS;
        tag   = w / (2 * SETS);
        found = 1'b0;
        way   = 0;
        for (int k = 0; k < 2; k++) begin
            if (m_valid[set][k] && m_tag[set][k] == tag) begin
                found = 1'b1;
                way   = k;
            end
        end
        if (!found) begin
            way = !m_mru[set];  // least recently used
            if (m_valid[set][way] && m_dirty[set][way]) begin
                queue_block(1'b1, m_tag[set][way] * 2 * SETS + set * 2);
            end
            queue_block(1'b0, w - w % 2);
        end
        dmemren   <= !is_store;
        dmemwen   <= is_store;
        dmemaddr  <= word_t'(w) << 2;
        dmemstore <= data;
        @(negedge CLK);
        check_bit("dhit", dhit, found);
        while (exp_word.size() > 0) begin
            @(posedge CLK);
            @(negedge CLK);
            check_bit("dhit", dhit, 1'b0);
            check_transfer();
        end
        if (!found) begin
            @(posedge CLK);
            @(negedge CLK);
            check_bit("dhit", dhit, 1'b1);  // retry after the fill
            m_valid[set][way] = 1'b1;
            m_dirty[set][way] = 1'b0;
            m_tag[set][way]   = tag;
        end
        check_bit("dren", dren, 1'b0);  // no memory transfer as the access completes
        check_bit("dwen", dwen, 1'b0);
        if (!is_store) begin
            check_word("dmemload", dmemload, ref_mem[w]);
        end else begin
            m_dirty[set][way] = 1'b1;
            ref_mem[w]        = data;
        end
        m_mru[set] = (way == 1);
        @(posedge CLK);
    endtask

    task automatic run_flush();
        for (int v = 0; v < 2; v++) begin
            for (int s = 0; s < SETS; s++) begin
                if (m_valid[s][v] && m_dirty[s][v]) begin
                    queue_block(1'b1, m_tag[s][v] * 2 * SETS + s * 2);
                end
            end
        end
        dmemren <= 1'b0;
        dmemwen <= 1'b0;
        halt    <= 1'b1;
        @(negedge CLK);
        while (!flushed) begin
            check_bit("dren", dren, 1'b0);
            if (dwen && exp_word.size() == 0) begin
                stop_with_failure("write-back of a line the model holds clean");
            end else if (dwen) begin
                check_transfer();
            end
            @(negedge CLK);
        end
        if (exp_word.size() != 0) begin
            stop_with_failure("flushed rose before every dirty line was written back");
        end
    endtask

    initial begin
        word_t pick;
        word_t data;
        wait_rng  = ~SEED;
        nRST      = 1'b0;
        dmemren   = 1'b0;
        dmemwen   = 1'b0;
        dmemaddr  = '0;
        dmemstore = '0;
        halt      = 1'b0;
        dwait     = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i]     = 32'h5a000000 ^ (word_t'(i) * 32'h00010203);
            ref_mem[i] = mem[i];
        end
        for (int s = 0; s < SETS; s++) begin
            m_mru[s] = 1'b0;
            for (int k = 0; k < 2; k++) begin
                m_valid[s][k] = 1'b0;
                m_dirty[s][k] = 1'b0;
                m_tag[s][k]   = 0;
            end
        end
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_bit("dhit", dhit, 1'b0);
        check_bit("dren", dren, 1'b0);
        check_bit("dwen", dwen, 1'b0);
        check_bit("flushed", flushed, 1'b0);
        @(posedge CLK);
        pick = SEED;
        for (int n = 0; n < N_OPS; n++) begin
            pick = xorshift32(pick);
            data = xorshift32(pick ^ 32'h0f0f0f0f);
            run_access(pick[8], int'(pick[5:0]), data);
        end
        run_flush();
        repeat (4) begin
            @(negedge CLK);
            check_bit("flushed", flushed, 1'b1);
        end
        for (int i = 0; i < 64; i++) begin
            check_word($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule
